//--- Makefile
TOP := tb_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- list.f
+incdir+testbench
source/core_pkg.sv
source/instr_intake.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/core_top.sv
testbench/tb_core.sv

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL function codes
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;
    localparam logic [5:0] FN_NOR   = 6'h27;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_SLTU  = 6'h2b;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_fields_t;

    // One instruction word, seen as either format
    typedef union packed {
        r_fields_t rtype;
        i_fields_t itype;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_HI,
        WB_LO
    } wb_src_e;

    typedef enum logic {
        HILO_PROD,
        HILO_RS
    } hilo_src_e;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [DATA_W-1:0]     opr1;
        logic [DATA_W-1:0]     opr2;
        logic [4:0]            shamt;
        logic                  mult_signed;
        logic                  gpr_we;
        logic [REG_ADDR_W-1:0] waddr;
        wb_src_e               wb_src;
        logic                  hi_we;
        logic                  lo_we;
        hilo_src_e             hilo_src;
    } exec_ctl_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_W-1:0]     alu_result;
        logic [DATA_W-1:0]     prod_hi;
        logic [DATA_W-1:0]     prod_lo;
        logic [DATA_W-1:0]     rs_value;
        logic                  gpr_we;
        logic [REG_ADDR_W-1:0] waddr;
        wb_src_e               wb_src;
        logic                  hi_we;
        logic                  lo_we;
        hilo_src_e             hilo_src;
    } result_ctl_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] waddr;
        logic [DATA_W-1:0]     wdata;
    } wb_t;

endpackage

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; (
    input  wire    i_clk,
    input  wire    i_reset,
    input  wire    i_instr_req,
    input  instr_u i_instr_data,
    output logic   o_instr_ack,
    output wb_t    o_wb
);

    logic                  id_valid;
    instr_u                id_instr;
    logic [REG_ADDR_W-1:0] gpr_raddr1;
    logic [REG_ADDR_W-1:0] gpr_raddr2;
    logic [DATA_W-1:0]     gpr_rdata1;
    logic [DATA_W-1:0]     gpr_rdata2;
    exec_ctl_t             exe_ctl;
    result_ctl_t           res_ctl;

    instr_intake intake_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_instr_req  (i_instr_req),
        .i_instr_data (i_instr_data),
        .o_instr_ack  (o_instr_ack),
        .o_valid      (id_valid),
        .o_instr      (id_instr)
    );

    decode_stage decode_inst (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_valid  (id_valid),
        .i_instr  (id_instr),
        .o_raddr1 (gpr_raddr1),
        .o_raddr2 (gpr_raddr2),
        .i_rdata1 (gpr_rdata1),
        .i_rdata2 (gpr_rdata2),
        .o_exec   (exe_ctl)
    );

    // Write-back record doubles as the GPR write port
    reg_file gpr_inst (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_raddr1 (gpr_raddr1),
        .i_raddr2 (gpr_raddr2),
        .o_rdata1 (gpr_rdata1),
        .o_rdata2 (gpr_rdata2),
        .i_wb     (o_wb)
    );

    execute_stage execute_inst (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_exec   (exe_ctl),
        .o_result (res_ctl)
    );

    result_stage result_inst (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_result (res_ctl),
        .o_wb     (o_wb)
    );

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage import core_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_valid,
    input  instr_u                 i_instr,
    output logic [REG_ADDR_W-1:0]  o_raddr1,
    output logic [REG_ADDR_W-1:0]  o_raddr2,
    input  wire [DATA_W-1:0]       i_rdata1,
    input  wire [DATA_W-1:0]       i_rdata2,
    output exec_ctl_t              o_exec
);

    exec_ctl_t         exec_d;
    logic [DATA_W-1:0] imm_sext;
    logic [DATA_W-1:0] imm_zext;
    logic [DATA_W-1:0] imm_upper;

    assign o_raddr1 = i_instr.rtype.rs;
    assign o_raddr2 = i_instr.rtype.rt;

    assign imm_sext  = {{(DATA_W-16){i_instr.itype.imm[15]}}, i_instr.itype.imm};
    assign imm_zext  = {{(DATA_W-16){1'b0}}, i_instr.itype.imm};
    assign imm_upper = {i_instr.itype.imm, 16'h0000};

    always_comb begin
        exec_d             = '0;
        exec_d.valid       = i_valid;
        exec_d.alu_op      = ALU_ADD;
        exec_d.opr1        = i_rdata1;
        exec_d.opr2        = i_rdata2;
        exec_d.shamt       = i_instr.rtype.shamt;
        exec_d.waddr       = i_instr.rtype.rd;
        exec_d.wb_src      = WB_ALU;
        exec_d.hilo_src    = HILO_PROD;

        case (i_instr.rtype.opcode)
            OP_SPECIAL: begin
                exec_d.gpr_we = 1'b1;
                case (i_instr.rtype.funct)
                    FN_SLL:  exec_d.alu_op = ALU_SLL;
                    FN_SRL:  exec_d.alu_op = ALU_SRL;
                    FN_SRA:  exec_d.alu_op = ALU_SRA;
                    FN_ADDU: exec_d.alu_op = ALU_ADD;
                    FN_SUBU: exec_d.alu_op = ALU_SUB;
                    FN_AND:  exec_d.alu_op = ALU_AND;
                    FN_OR:   exec_d.alu_op = ALU_OR;
                    FN_XOR:  exec_d.alu_op = ALU_XOR;
                    FN_NOR:  exec_d.alu_op = ALU_NOR;
                    FN_SLT:  exec_d.alu_op = ALU_SLT;
                    FN_SLTU: exec_d.alu_op = ALU_SLTU;
                    FN_MFHI: exec_d.wb_src = WB_HI;
                    FN_MFLO: exec_d.wb_src = WB_LO;
                    FN_MTHI: begin
                        exec_d.gpr_we   = 1'b0;
                        exec_d.hi_we    = 1'b1;
                        exec_d.hilo_src = HILO_RS;
                    end
                    FN_MTLO: begin
                        exec_d.gpr_we   = 1'b0;
                        exec_d.lo_we    = 1'b1;
                        exec_d.hilo_src = HILO_RS;
                    end
                    FN_MULT, FN_MULTU: begin
                        exec_d.gpr_we      = 1'b0;
                        exec_d.hi_we       = 1'b1;
                        exec_d.lo_we       = 1'b1;
                        exec_d.mult_signed = (i_instr.rtype.funct == FN_MULT);
                    end
                    default: exec_d.gpr_we = 1'b0;
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                // I-type writes rt
                exec_d.gpr_we = 1'b1;
                exec_d.waddr  = i_instr.itype.rt;
                case (i_instr.itype.opcode)
                    OP_ADDIU: begin
                        exec_d.alu_op = ALU_ADD;
                        exec_d.opr2   = imm_sext;
                    end
                    OP_SLTI: begin
                        exec_d.alu_op = ALU_SLT;
                        exec_d.opr2   = imm_sext;
                    end
                    OP_SLTIU: begin
                        exec_d.alu_op = ALU_SLTU;
                        exec_d.opr2   = imm_sext;
                    end
                    OP_ANDI: begin
                        exec_d.alu_op = ALU_AND;
                        exec_d.opr2   = imm_zext;
                    end
                    OP_ORI: begin
                        exec_d.alu_op = ALU_OR;
                        exec_d.opr2   = imm_zext;
                    end
                    OP_XORI: begin
                        exec_d.alu_op = ALU_XOR;
                        exec_d.opr2   = imm_zext;
                    end
                    default: begin
                        exec_d.alu_op = ALU_LUI;
                        exec_d.opr2   = imm_upper;
                    end
                endcase
            end
            default: exec_d.gpr_we = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_exec.valid <= 1'b0;
        end else begin
            o_exec <= exec_d;
        end
    end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage import core_pkg::*; (
    input  wire         i_clk,
    input  wire         i_reset,
    input  exec_ctl_t   i_exec,
    output result_ctl_t o_result
);

    logic [DATA_W-1:0]          alu_result;
    logic signed [2*DATA_W-1:0] mul_a;
    logic signed [2*DATA_W-1:0] mul_b;
    logic [2*DATA_W-1:0]        product;

    always_comb begin
        case (i_exec.alu_op)
            ALU_ADD:  alu_result = i_exec.opr1 + i_exec.opr2;
            ALU_SUB:  alu_result = i_exec.opr1 - i_exec.opr2;
            ALU_AND:  alu_result = i_exec.opr1 & i_exec.opr2;
            ALU_OR:   alu_result = i_exec.opr1 | i_exec.opr2;
            ALU_XOR:  alu_result = i_exec.opr1 ^ i_exec.opr2;
            ALU_NOR:  alu_result = ~(i_exec.opr1 | i_exec.opr2);
            ALU_SLT: begin
                alu_result = {{(DATA_W-1){1'b0}},
                              $signed(i_exec.opr1) < $signed(i_exec.opr2)};
            end
            ALU_SLTU: begin
                alu_result = {{(DATA_W-1){1'b0}}, i_exec.opr1 < i_exec.opr2};
            end
            ALU_SLL:  alu_result = i_exec.opr2 << i_exec.shamt;
            ALU_SRL:  alu_result = i_exec.opr2 >> i_exec.shamt;
            ALU_SRA:  alu_result = $signed(i_exec.opr2) >>> i_exec.shamt;
            ALU_LUI:  alu_result = i_exec.opr2;
            default:  alu_result = '0;
        endcase
    end

    // Extend to 64 bits so one signed multiply covers mult and multu
    always_comb begin
        if (i_exec.mult_signed) begin
            mul_a = {{DATA_W{i_exec.opr1[DATA_W-1]}}, i_exec.opr1};
            mul_b = {{DATA_W{i_exec.opr2[DATA_W-1]}}, i_exec.opr2};
        end else begin
            mul_a = {{DATA_W{1'b0}}, i_exec.opr1};
            mul_b = {{DATA_W{1'b0}}, i_exec.opr2};
        end
        product = mul_a * mul_b;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_result.valid <= 1'b0;
        end else begin
            o_result.valid      <= i_exec.valid;
            o_result.alu_result <= alu_result;
            o_result.prod_hi    <= product[2*DATA_W-1:DATA_W];
            o_result.prod_lo    <= product[DATA_W-1:0];
            o_result.rs_value   <= i_exec.opr1;
            o_result.gpr_we     <= i_exec.gpr_we;
            o_result.waddr      <= i_exec.waddr;
            o_result.wb_src     <= i_exec.wb_src;
            o_result.hi_we      <= i_exec.hi_we;
            o_result.lo_we      <= i_exec.lo_we;
            o_result.hilo_src   <= i_exec.hilo_src;
        end
    end

endmodule

`default_nettype wire

//--- source/instr_intake.sv
`timescale 1ns/100ps
`default_nettype none

module instr_intake import core_pkg::*; (
    input  wire    i_clk,
    input  wire    i_reset,
    input  wire    i_instr_req,
    input  instr_u i_instr_data,
    output logic   o_instr_ack,
    output logic   o_valid,
    output instr_u o_instr
);

    logic accept;

    // New word only once the previous ack has dropped
    assign accept = i_instr_req && !o_instr_ack;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_instr_ack <= 1'b0;
            o_valid     <= 1'b0;
        end else begin
            o_valid <= accept;
            if (accept) begin
                o_instr_ack <= 1'b1;
            end else if (o_instr_ack && !i_instr_req) begin
                o_instr_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_instr <= i_instr_data;
        end
    end

    a_ack_follows_req: assert property (
        @(posedge i_clk) disable iff (i_reset)
        $rose(o_instr_ack) |-> $past(i_instr_req)
    );

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire [REG_ADDR_W-1:0]   i_raddr1,
    input  wire [REG_ADDR_W-1:0]   i_raddr2,
    output logic [DATA_W-1:0]      o_rdata1,
    output logic [DATA_W-1:0]      o_rdata2,
    input  wb_t                    i_wb
);

    logic [DATA_W-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.valid && i_wb.waddr != '0) begin
            regs[i_wb.waddr] <= i_wb.wdata;
        end
    end

    // r0 always reads as zero
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

//--- source/result_stage.sv
`timescale 1ns/100ps
`default_nettype none

module result_stage import core_pkg::*; (
    input  wire         i_clk,
    input  wire         i_reset,
    input  result_ctl_t i_result,
    output wb_t         o_wb
);

    logic [DATA_W-1:0] hi_q;
    logic [DATA_W-1:0] lo_q;
    logic [DATA_W-1:0] hi_d;
    logic [DATA_W-1:0] lo_d;
    logic [DATA_W-1:0] wdata;
    logic              wb_valid;

    assign hi_d = (i_result.hilo_src == HILO_RS) ? i_result.rs_value : i_result.prod_hi;
    assign lo_d = (i_result.hilo_src == HILO_RS) ? i_result.rs_value : i_result.prod_lo;

    // mfhi/mflo see HI and LO before this cycle's update
    always_comb begin
        case (i_result.wb_src)
            WB_HI:   wdata = hi_q;
            WB_LO:   wdata = lo_q;
            default: wdata = i_result.alu_result;
        endcase
    end

    assign wb_valid = i_result.valid && i_result.gpr_we && (i_result.waddr != '0);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (i_result.valid) begin
            if (i_result.hi_we) begin
                hi_q <= hi_d;
            end
            if (i_result.lo_we) begin
                lo_q <= lo_d;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb.valid <= 1'b0;
        end else begin
            o_wb.valid <= wb_valid;
            o_wb.waddr <= i_result.waddr;
            o_wb.wdata <= wdata;
        end
    end

    // No record ever targets r0
    a_wb_not_r0: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_wb.valid |-> (o_wb.waddr != '0)
    );

endmodule

`default_nettype wire

//--- testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Architectural state as the ISA defines it
logic [31:0] model_gpr [32];
logic [31:0] model_hi;
logic [31:0] model_lo;

function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] shamt,
                                         input logic [5:0] funct);
    return {OP_SPECIAL, rs, rt, rd, shamt, funct};
endfunction

function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

task automatic clear_model();
    for (int i = 0; i < 32; i++) begin
        model_gpr[i] = '0;
    end
    model_hi = '0;
    model_lo = '0;
endtask

// Executes one word and returns the record the core owes for it
task automatic apply_model(input logic [31:0] word, output logic has_rec, output wb_t rec);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  sa;
    logic [4:0]  dest;
    logic [15:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] res;
    logic [63:0] prod;
    logic        writes;
    op     = word[31:26];
    rs     = word[25:21];
    rt     = word[20:16];
    sa     = word[10:6];
    fn     = word[5:0];
    imm    = word[15:0];
    a      = model_gpr[rs];
    b      = model_gpr[rt];
    simm   = {{16{imm[15]}}, imm};
    res    = '0;
    writes = 1'b1;
    if (op == OP_SPECIAL) begin
        dest = word[15:11];
        case (fn)
            FN_ADDU: res = a + b;
            FN_SUBU: res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_XOR:  res = a ^ b;
            FN_NOR:  res = ~(a | b);
            FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
            FN_SLTU: res = {31'd0, a < b};
            FN_SLL:  res = b << sa;
            FN_SRL:  res = b >> sa;
            FN_SRA:  res = $signed(b) >>> sa;
            FN_MFHI: res = model_hi;
            FN_MFLO: res = model_lo;
            FN_MTHI: begin
                writes   = 1'b0;
                model_hi = a;
            end
            FN_MTLO: begin
                writes   = 1'b0;
                model_lo = a;
            end
            FN_MULT: begin
                writes   = 1'b0;
                prod     = longint'($signed(a)) * longint'($signed(b));
                model_hi = prod[63:32];
                model_lo = prod[31:0];
            end
            FN_MULTU: begin
                writes   = 1'b0;
                prod     = {32'd0, a} * {32'd0, b};
                model_hi = prod[63:32];
                model_lo = prod[31:0];
            end
            default: writes = 1'b0;
        endcase
    end else begin
        dest = rt;
        case (op)
            OP_ADDIU: res = a + simm;
            OP_SLTI:  res = {31'd0, $signed(a) < $signed(simm)};
            OP_SLTIU: res = {31'd0, a < simm};
            OP_ANDI:  res = a & {16'd0, imm};
            OP_ORI:   res = a | {16'd0, imm};
            OP_XORI:  res = a ^ {16'd0, imm};
            OP_LUI:   res = {imm, 16'd0};
            default:  writes = 1'b0;
        endcase
    end
    // Writes to r0 leave no trace
    has_rec   = writes && (dest != 5'd0);
    rec.valid = has_rec;
    rec.waddr = dest;
    rec.wdata = res;
    if (has_rec) begin
        model_gpr[dest] = res;
    end
endtask

`endif

//--- testbench/tb_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core import core_pkg::*; ();

    localparam int NUM_RANDOM = 400;
    localparam int HS_TIMEOUT = 16;
    localparam int WB_LATENCY = 3;

    localparam logic [5:0] ALU_FN [8] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR,
                                          FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    localparam logic [5:0] SHIFT_FN [4] = '{FN_SLL, FN_SRL, FN_SRA, FN_SRA};
    localparam logic [5:0] IMM_OP [8] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
                                          OP_ORI, OP_XORI, OP_LUI, OP_ADDIU};

    logic        clk;
    logic        reset;
    logic        instr_req;
    logic [31:0] instr_data;
    logic        instr_ack;
    wb_t         wb;

    logic [15:0] lfsr_state;
    int          cycle_cnt;
    logic        exp_pending;
    int          exp_cycle;
    wb_t         exp_rec;
    logic        hung;
    int          value_errors;
    int          record_errors;
    int          protocol_errors;
    int          timeout_errors;

    `include "tb_model.svh"

    core_top uut (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_instr_req  (instr_req),
        .i_instr_data (instr_data),
        .o_instr_ack  (instr_ack),
        .o_wb         (wb)
    );

    always #10 clk = ~clk;

    function automatic logic lfsr_step();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [31:0] random_instr();
        logic [3:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sel;
        logic [15:0] imm;
        kind = 4'(rand_bits(4));
        rs   = 5'(rand_bits(5));
        rt   = 5'(rand_bits(5));
        rd   = 5'(rand_bits(5));
        sel  = 5'(rand_bits(5));
        imm  = 16'(rand_bits(16));
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3: return encode_r(rs, rt, rd, 5'd0, ALU_FN[sel[2:0]]);
            4'd4, 4'd5: return encode_r(rs, rt, rd, sel, SHIFT_FN[imm[1:0]]);
            4'd10: return encode_r(rs, rt, 5'd0, 5'd0, sel[0] ? FN_MULT : FN_MULTU);
            4'd11: return encode_r(5'd0, 5'd0, rd, 5'd0, sel[0] ? FN_MFHI : FN_MFLO);
            4'd12: return encode_r(rs, 5'd0, 5'd0, 5'd0, sel[0] ? FN_MTHI : FN_MTLO);
            // Opcodes 0x20 and up are no-ops for this core
            4'd13: return {1'b1, rd, rs, rt, imm};
            default: return encode_i(IMM_OP[sel[2:0]], rs, rt, imm);
        endcase
    endfunction

    // One clock edge, with the write-back check at that edge
    task automatic tick();
        @(posedge clk);
        cycle_cnt++;
        if (wb.valid) begin
            if (!exp_pending) begin
                $display("[%0t] Unexpected write-back record to r%0d", $time, wb.waddr);
                record_errors++;
            end else begin
                if (cycle_cnt != exp_cycle) begin
                    $display("[%0t] Write-back record came at cycle %0d, due at cycle %0d",
                             $time, cycle_cnt, exp_cycle);
                    protocol_errors++;
                end
                if (wb.waddr != exp_rec.waddr) begin
                    $display("Mismatch at %0t: o_wb.waddr got %0d expected %0d",
                             $time, wb.waddr, exp_rec.waddr);
                    value_errors++;
                end
                if (wb.wdata != exp_rec.wdata) begin
                    $display("Mismatch at %0t: o_wb.wdata got %h expected %h",
                             $time, wb.wdata, exp_rec.wdata);
                    value_errors++;
                end
                exp_pending = 1'b0;
            end
        end else if (exp_pending && cycle_cnt >= exp_cycle) begin
            $display("[%0t] Write-back record for r%0d never arrived", $time, exp_rec.waddr);
            record_errors++;
            exp_pending = 1'b0;
        end
    endtask

    task automatic send_instr(input logic [31:0] word);
        int   waited;
        logic has_rec;
        wb_t  rec;
        if (hung) begin
            return;
        end
        instr_req  <= 1'b1;
        instr_data <= word;
        waited = 0;
        do begin
            tick();
            waited++;
        end while (!instr_ack && waited < HS_TIMEOUT);
        if (!instr_ack) begin
            $display("[%0t] Timeout waiting for o_instr_ack to rise", $time);
            timeout_errors++;
            hung = 1'b1;
            return;
        end
        if (waited != 2) begin
            $display("[%0t] o_instr_ack rose %0d edges after req, expected 2", $time, waited);
            protocol_errors++;
        end
        apply_model(word, has_rec, rec);
        if (has_rec) begin
            exp_pending = 1'b1;
            exp_cycle   = cycle_cnt + WB_LATENCY;
            exp_rec     = rec;
        end
        instr_req <= 1'b0;
        waited = 0;
        do begin
            tick();
            waited++;
        end while (instr_ack && waited < HS_TIMEOUT);
        if (instr_ack) begin
            $display("[%0t] Timeout waiting for o_instr_ack to fall", $time);
            timeout_errors++;
            hung = 1'b1;
            return;
        end
        if (waited != 2) begin
            $display("[%0t] o_instr_ack fell %0d edges after req, expected 2", $time, waited);
            protocol_errors++;
        end
    endtask

    initial begin
        int waited;
        clk             = 1'b0;
        reset           = 1'b1;
        instr_req       = 1'b0;
        instr_data      = '0;
        lfsr_state      = 16'd42113;
        cycle_cnt       = 0;
        exp_pending     = 1'b0;
        exp_cycle       = 0;
        exp_rec         = '0;
        hung            = 1'b0;
        value_errors    = 0;
        record_errors   = 0;
        protocol_errors = 0;
        timeout_errors  = 0;
        clear_model();

        repeat (8) tick();
        reset <= 1'b0;
        tick();
        if (instr_ack !== 1'b0) begin
            $display("Mismatch at %0t: o_instr_ack got %b expected 0", $time, instr_ack);
            value_errors++;
        end
        if (wb.valid !== 1'b0) begin
            $display("Mismatch at %0t: o_wb.valid got %b expected 0", $time, wb.valid);
            value_errors++;
        end

        // Operands with the sign bit set and a small negative value
        send_instr(encode_i(OP_LUI, 5'd0, 5'd1, 16'h8000));
        send_instr(encode_i(OP_ORI, 5'd1, 5'd1, 16'h1234));
        send_instr(encode_i(OP_ADDIU, 5'd0, 5'd2, 16'hfffd));
        send_instr(encode_r(5'd1, 5'd0, 5'd0, 5'd0, FN_MTHI));
        send_instr(encode_r(5'd2, 5'd0, 5'd0, 5'd0, FN_MTLO));
        send_instr(encode_r(5'd0, 5'd0, 5'd3, 5'd0, FN_MFHI));
        send_instr(encode_r(5'd0, 5'd0, 5'd4, 5'd0, FN_MFLO));
        // Same operands, signed then unsigned product
        send_instr(encode_r(5'd1, 5'd2, 5'd0, 5'd0, FN_MULT));
        send_instr(encode_r(5'd0, 5'd0, 5'd5, 5'd0, FN_MFHI));
        send_instr(encode_r(5'd0, 5'd0, 5'd6, 5'd0, FN_MFLO));
        send_instr(encode_r(5'd1, 5'd2, 5'd0, 5'd0, FN_MULTU));
        send_instr(encode_r(5'd0, 5'd0, 5'd5, 5'd0, FN_MFHI));
        send_instr(encode_r(5'd0, 5'd0, 5'd6, 5'd0, FN_MFLO));
        send_instr(encode_r(5'd0, 5'd1, 5'd7, 5'd12, FN_SRA));
        // No-ops, a write to r0, then r0 as an operand
        send_instr(32'h0000_0000);
        send_instr(32'hac22_0010);
        send_instr(encode_r(5'd1, 5'd0, 5'd0, 5'd0, 6'h08));
        send_instr(encode_i(OP_ADDIU, 5'd2, 5'd0, 16'h7fff));
        send_instr(encode_r(5'd0, 5'd2, 5'd8, 5'd0, FN_SUBU));

        for (int i = 0; i < NUM_RANDOM; i++) begin
            send_instr(random_instr());
        end

        waited = 0;
        while (exp_pending && waited < HS_TIMEOUT) begin
            tick();
            waited++;
        end
        // A few idle edges to catch stray records
        repeat (4) tick();

        $display("Errors: %0d value, %0d record, %0d protocol, %0d timeout",
                 value_errors, record_errors, protocol_errors, timeout_errors);
        if (value_errors + record_errors + protocol_errors + timeout_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
